/* Bender.yml */
package:
  name: decode_unit

dependencies: {}

sources:
  - files:
      - hdl/decodePkg.sv
      - hdl/dFormatDecoder.sv
      - hdl/dsFormatDecoder.sv
      - hdl/xFormatDecoder.sv
      - hdl/decodeMerge.sv
      - hdl/decodeUnit.sv
  - target: test
    files:
      - bench/decodeUnitTb.sv

/* bench/decodeUnitTb.sv */
`timescale 1ns/10ps

module decodeUnitTb;
	import decodePkg::*;

	localparam int addressSize = 64;
	localparam int clockPeriod = 4;
	localparam int resetCycles = 16;
	localparam int totalCycles = resetCycles + 20 + 300 + 200 + 300 + 200 + 400 + 4;

	// kinds of instruction the stimulus can build
	localparam int idleKind = 0;
	localparam int dKind = 1;
	localparam int dsKind = 2;
	localparam int xKind = 3;
	localparam int invalidKind = 4;
	localparam int mixedKind = 5;

	typedef struct packed
	{
		logic en;
		decodedInstr_t rec;
		logic [0:addressSize-1] addr;
	} expect_t;

	logic clock;
	logic arstN;
	logic enable;
	logic [0:instrWidth-1] instruction;
	logic [0:addressSize-1] address;
	decodedInstr_t decoded;
	logic [0:addressSize-1] addressOut;

	integer seed = 32'hf482b02d;
	int checks = 0;
	int errors = 0;
	expect_t pending[$];

	decodeUnit #(.addressSize(addressSize)) dut0 (
		.clock_i(clock),
		.arstN_i(arstN),
		.enable_i(enable),
		.instruction_i(instruction),
		.instructionAddress_i(address),
		.decoded_o(decoded),
		.instructionAddress_o(addressOut)
	);

	always #(clockPeriod / 2) clock = ~clock;

	//////////////////////////////
	// reference decode model
	//////////////////////////////
	function automatic logic isKnownOp(input logic [0:5] op);
		return op inside {opAddi, opAddis, opOri, opAndiDot, opLwz, opStw, opLd, opStd, opExt31};
	endfunction

	function automatic logic isKnownXo(input logic [0:9] xo);
		return xo inside {xoCmp, xoAnd, xoXor, xoOr, xoAdd};
	endfunction

	function automatic decodedInstr_t expectDecode(input logic [0:instrWidth-1] w);
		decodedInstr_t r;
		logic [0:5] op;
		logic [0:9] xo;
		logic [0:15] imm16;
		logic [0:13] imm14;
		logic logical;
		op = w[0:5];
		xo = w[21:30];
		imm16 = w[16:31];
		imm14 = w[16:29];
		logical = (op == opOri) || (op == opAndiDot);
		r = '0;
		r.valid = 1'b1;
		r.opcode = primaryOp_e'(op);
		r.format = fmtInvalid;
		if (op inside {opAddi, opAddis, opOri, opAndiDot, opLwz, opStw})
		begin
			r.format = fmtD;
			r.reg1En = 1'b1;
			r.reg2En = 1'b1;
			r.immValid = 1'b1;
			// logical immediates write RA from RS
			r.reg1 = logical ? w[11:15] : w[6:10];
			r.reg2 = logical ? w[6:10] : w[11:15];
			r.reg2ValOrZero = !logical;
			r.bit1 = (op == opAndiDot);
			if (op == opAddis)
				r.imm = {{32{imm16[0]}}, imm16, 16'h0000};
			else if (logical)
				r.imm = {48'h0, imm16};
			else
				r.imm = {{48{imm16[0]}}, imm16};
		end
		else if ((op == opLd || op == opStd) && w[30:31] == 2'b00)
		begin
			r.format = fmtDS;
			r.reg1 = w[6:10];
			r.reg1En = 1'b1;
			r.reg2 = w[11:15];
			r.reg2En = 1'b1;
			r.imm = {{48{imm14[0]}}, imm14, 2'b00};
			r.immValid = 1'b1;
			r.reg2ValOrZero = 1'b1;
		end
		else if (op == opExt31 && isKnownXo(xo))
		begin
			r.format = fmtX;
			r.xOpcode = extOp_e'(xo);
			r.xOpcodeValid = 1'b1;
			r.reg1 = w[6:10];
			r.reg2 = w[11:15];
			r.reg3 = w[16:20];
			if (xo == xoAnd || xo == xoOr || xo == xoXor)
			begin
				r.reg1 = w[11:15];
				r.reg2 = w[6:10];
			end
			else if (xo == xoCmp)
				r.reg1 = {2'b00, w[6:8]};
			r.reg1En = 1'b1;
			r.reg2En = 1'b1;
			r.reg3En = 1'b1;
			r.bit1 = w[31];
		end
		return r;
	endfunction

	//////////////////////////////
	// stimulus
	//////////////////////////////
	function automatic logic [0:5] dOpcode(input int idx);
		case (idx)
			0: return opAddi;
			1: return opAddis;
			2: return opOri;
			3: return opAndiDot;
			4: return opLwz;
			default: return opStw;
		endcase
	endfunction

	function automatic logic [0:9] xOpcode(input int idx);
		case (idx)
			0: return xoCmp;
			1: return xoAnd;
			2: return xoXor;
			3: return xoOr;
			default: return xoAdd;
		endcase
	endfunction

	task automatic makeInstruction(input int kind, output logic [0:instrWidth-1] w);
		logic [0:31] r;
		logic [0:5] op;
		logic [0:9] xo;
		int pick;
		int sub;
		r = $random(seed);
		sub = $unsigned($random(seed)) % 3;
		pick = kind;
		// one word in eight is unknown in the mixed run
		if (kind == mixedKind)
			pick = (($random(seed) & 7) == 0) ? invalidKind : 1 + ($unsigned($random(seed)) % 3);
		op = r[0:5];
		while (isKnownOp(op))
			op = op + 6'd1;
		xo = r[21:30];
		while (isKnownXo(xo))
			xo = xo + 10'd1;
		case (pick)
			dKind: w = {dOpcode($unsigned($random(seed)) % 6), r[6:31]};
			dsKind: w = {(r[0] ? opLd : opStd), r[6:29], 2'b00};
			xKind: w = {opExt31, r[6:20], xOpcode($unsigned($random(seed)) % 5), r[31]};
			invalidKind:
			begin
				if (sub == 0)
					w = {op, r[6:31]};
				else if (sub == 1)
					w = {opExt31, r[6:20], xo, r[31]};
				else
					w = {(r[0] ? opLd : opStd), r[6:29], (r[30:31] == 2'b00) ? 2'b01 : r[30:31]};
			end
			default: w = r;
		endcase
	endtask

	//////////////////////////////
	// checks
	//////////////////////////////
	task automatic checkValue(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h at %0t", name, got, exp, $time);
			errors++;
		end
	endtask

	task automatic compareOutput(input expect_t e);
		checks++;
		if (!e.en)
			checkValue("decoded_o.valid", decoded.valid, 1'b0);
		else
		begin
			checkValue("decoded_o.valid", decoded.valid, 1'b1);
			checkValue("decoded_o.format", decoded.format, e.rec.format);
			checkValue("decoded_o.opcode", decoded.opcode, e.rec.opcode);
			checkValue("decoded_o.xOpcodeValid", decoded.xOpcodeValid, e.rec.xOpcodeValid);
			checkValue("decoded_o.reg1En", decoded.reg1En, e.rec.reg1En);
			checkValue("decoded_o.reg2En", decoded.reg2En, e.rec.reg2En);
			checkValue("decoded_o.reg3En", decoded.reg3En, e.rec.reg3En);
			checkValue("decoded_o.immValid", decoded.immValid, e.rec.immValid);
			checkValue("decoded_o.reg2ValOrZero", decoded.reg2ValOrZero, e.rec.reg2ValOrZero);
			checkValue("decoded_o.bit1", decoded.bit1, e.rec.bit1);
			checkValue("instructionAddress_o", addressOut, e.addr);
			if (e.rec.xOpcodeValid)
				checkValue("decoded_o.xOpcode", decoded.xOpcode, e.rec.xOpcode);
			if (e.rec.reg1En)
				checkValue("decoded_o.reg1", decoded.reg1, e.rec.reg1);
			if (e.rec.reg2En)
				checkValue("decoded_o.reg2", decoded.reg2, e.rec.reg2);
			if (e.rec.reg3En)
				checkValue("decoded_o.reg3", decoded.reg3, e.rec.reg3);
			if (e.rec.immValid)
				checkValue("decoded_o.imm", decoded.imm, e.rec.imm);
		end
	endtask

	// outputs settle after the rising edge, so compare and drive on the falling one
	task automatic runTest(input string name, input int cycles, input int kind);
		expect_t now;
		int startErrors;
		logic [0:instrWidth-1] w;
		startErrors = errors;
		repeat (cycles)
		begin
			@(negedge clock);
			compareOutput(pending.pop_front());
			makeInstruction(kind, w);
			now.en = 1'b0;
			if (kind == mixedKind)
				now.en = $random(seed) & 1;
			else if (kind != idleKind)
				now.en = ($random(seed) & 7) != 0;
			now.addr = {$random(seed), $random(seed)};
			now.rec = expectDecode(w);
			enable = now.en;
			instruction = w;
			address = now.addr;
			pending.push_back(now);
		end
		$display("test %s finished with %0d errors", name, errors - startErrors);
	endtask

	initial
	begin
		#((totalCycles + 50) * clockPeriod);
		$display("watchdog expired, the run took longer than its %0d cycles", totalCycles);
		$display("Test failures found");
		$finish;
	end

	initial
	begin
		expect_t idle;
		int startErrors;
		clock = 1'b0;
		arstN = 1'b0;
		enable = 1'b0;
		instruction = '0;
		address = '0;
		idle = '0;
		startErrors = errors;
		// two idle slots stand for the pipeline contents at reset
		pending.push_back(idle);
		pending.push_back(idle);
		// enable toggles during reset, valid must stay low
		repeat (resetCycles)
		begin
			@(negedge clock);
			checks++;
			checkValue("decoded_o.valid", decoded.valid, 1'b0);
			enable = 1'b1;
			instruction = $random(seed);
			address = {$random(seed), $random(seed)};
		end
		arstN = 1'b1;
		enable = 1'b0;
		$display("test reset hold finished with %0d errors", errors - startErrors);
		runTest("reset idle", 20, idleKind);
		runTest("D format", 300, dKind);
		runTest("DS format", 200, dsKind);
		runTest("X format", 300, xKind);
		runTest("invalid opcodes", 200, invalidKind);
		runTest("mixed with gaps", 400, mixedKind);
		runTest("drain", 4, idleKind);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* hdl/dFormatDecoder.sv */
`timescale 1ns/10ps

module dFormatDecoder
(
	input logic clock_i,
	input logic arstN_i,
	input logic enable_i,
	input logic [0:decodePkg::instrWidth-1] instruction_i,
	output decodePkg::dResult_t result_o
);
	import decodePkg::*;

	primaryOp_e opcode;
	dResult_t nextResult;
	dResult_t payloadQ;
	logic hitQ;

	assign opcode = primaryOp_e'(instruction_i[0:5]);

	// flags per opcode
	always_comb
	begin
		nextResult = '0;
		nextResult.reg1 = instruction_i[6:10];
		nextResult.reg2 = instruction_i[11:15];
		nextResult.imm = instruction_i[16:31];
		case (opcode)
			opAddi, opLwz, opStw:
			begin
				nextResult.hit = 1'b1;
				nextResult.immSigned = 1'b1;
				nextResult.reg2ValOrZero = 1'b1;
			end
			opAddis:
			begin
				nextResult.hit = 1'b1;
				nextResult.immSigned = 1'b1;
				nextResult.immShift16 = 1'b1;
				nextResult.reg2ValOrZero = 1'b1;
			end
			opOri, opAndiDot:
			begin
				// logical ops write RA, so the fields swap
				nextResult.hit = 1'b1;
				nextResult.reg1 = instruction_i[11:15];
				nextResult.reg2 = instruction_i[6:10];
			end
			default:
			begin
				nextResult.hit = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			hitQ <= 1'b0;
		else if (enable_i)
			hitQ <= nextResult.hit;
	end

	always_ff @(posedge clock_i)
	begin
		if (enable_i)
			payloadQ <= nextResult;
	end

	always_comb
	begin
		result_o = payloadQ;
		result_o.hit = hitQ;
	end

endmodule

/* hdl/decodeMerge.sv */
`timescale 1ns/10ps

module decodeMerge #(
	parameter int addressSize = 64
)
(
	input logic clock_i,
	input logic arstN_i,
	input logic enable_i,
	input decodePkg::primaryOp_e opcode_i,
	input logic [0:addressSize-1] address_i,
	input decodePkg::dResult_t dResult_i,
	input decodePkg::dsResult_t dsResult_i,
	input decodePkg::xResult_t xResult_i,
	output decodePkg::decodedInstr_t decoded_o,
	output logic [0:addressSize-1] instructionAddress_o
);
	import decodePkg::*;

	logic [0:immWidth-1] dImmExt;
	logic [0:immWidth-1] dsImmExt;
	decodedInstr_t nextRecord;
	decodedInstr_t recordQ;
	logic [0:addressSize-1] addressQ;
	logic validQ;

	//////////////////////////////
	// implicit immediate ops
	//////////////////////////////
	always_comb
	begin
		if (dResult_i.immShift16)
			dImmExt = {{(immWidth-32){dResult_i.imm[0]}}, dResult_i.imm, 16'h0000};
		else if (dResult_i.immSigned)
			dImmExt = {{(immWidth-16){dResult_i.imm[0]}}, dResult_i.imm};
		else
			dImmExt = {{(immWidth-16){1'b0}}, dResult_i.imm};
	end

	// two zero bits appended, then sign extended
	assign dsImmExt = {{(immWidth-16){dsResult_i.imm[0]}}, dsResult_i.imm, 2'b00};

	//////////////////////////////
	// format select
	//////////////////////////////
	always_comb
	begin
		nextRecord = '0;
		nextRecord.valid = 1'b1;
		nextRecord.opcode = opcode_i;
		nextRecord.format = fmtInvalid;
		if (dResult_i.hit)
		begin
			nextRecord.format = fmtD;
			nextRecord.reg1 = dResult_i.reg1;
			nextRecord.reg1En = 1'b1;
			nextRecord.reg2 = dResult_i.reg2;
			nextRecord.reg2En = 1'b1;
			nextRecord.imm = dImmExt;
			nextRecord.immValid = 1'b1;
			nextRecord.reg2ValOrZero = dResult_i.reg2ValOrZero;
			nextRecord.bit1 = (opcode_i == opAndiDot);
		end
		else if (dsResult_i.hit)
		begin
			nextRecord.format = fmtDS;
			nextRecord.reg1 = dsResult_i.reg1;
			nextRecord.reg1En = 1'b1;
			nextRecord.reg2 = dsResult_i.reg2;
			nextRecord.reg2En = 1'b1;
			nextRecord.imm = dsImmExt;
			nextRecord.immValid = 1'b1;
			nextRecord.reg2ValOrZero = 1'b1;
		end
		else if (xResult_i.hit)
		begin
			nextRecord.format = fmtX;
			nextRecord.xOpcode = xResult_i.extOp;
			nextRecord.xOpcodeValid = 1'b1;
			nextRecord.reg1 = xResult_i.reg1;
			nextRecord.reg1En = 1'b1;
			nextRecord.reg2 = xResult_i.reg2;
			nextRecord.reg2En = 1'b1;
			nextRecord.reg3 = xResult_i.reg3;
			nextRecord.reg3En = 1'b1;
			nextRecord.bit1 = xResult_i.rc;
		end
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			validQ <= 1'b0;
		else
			validQ <= enable_i;
	end

	always_ff @(posedge clock_i)
	begin
		if (enable_i)
		begin
			recordQ <= nextRecord;
			addressQ <= address_i;
		end
	end

	always_comb
	begin
		decoded_o = recordQ;
		decoded_o.valid = validQ;
	end

	assign instructionAddress_o = addressQ;

	// stage one decoders must never both claim a word
	singleClaim: assert property (@(posedge clock_i) disable iff (!arstN_i)
		enable_i |-> $onehot0({dResult_i.hit, dsResult_i.hit, xResult_i.hit}));

endmodule

/* hdl/decodePkg.sv */
package decodePkg;

	//////////////////////////////
	// widths fixed by the ISA
	//////////////////////////////
	localparam int instrWidth = 32;
	localparam int immWidth = 64;

	typedef logic [0:4] regIdx_t;

	// primary opcode, instruction bits 0 to 5
	typedef enum logic [0:5]
	{
		opAddi = 6'd14,
		opAddis = 6'd15,
		opOri = 6'd24,
		opAndiDot = 6'd28,
		opExt31 = 6'd31,
		opLwz = 6'd32,
		opStw = 6'd36,
		opLd = 6'd58,
		opStd = 6'd62
	} primaryOp_e;

	// extended opcode under opcode 31, bits 21 to 30
	typedef enum logic [0:9]
	{
		xoCmp = 10'd0,
		xoAnd = 10'd28,
		xoAdd = 10'd266,
		xoXor = 10'd316,
		xoOr = 10'd444
	} extOp_e;

	typedef enum logic [0:1]
	{
		fmtInvalid,
		fmtD,
		fmtDS,
		fmtX
	} format_e;

	//////////////////////////////
	// stage one results
	//////////////////////////////
	typedef struct packed
	{
		logic hit;
		regIdx_t reg1;
		regIdx_t reg2;
		logic [0:15] imm;
		logic immSigned;
		logic immShift16;
		logic reg2ValOrZero;
	} dResult_t;

	typedef struct packed
	{
		logic hit;
		regIdx_t reg1;
		regIdx_t reg2;
		logic [0:13] imm;
	} dsResult_t;

	typedef struct packed
	{
		logic hit;
		regIdx_t reg1;
		regIdx_t reg2;
		regIdx_t reg3;
		extOp_e extOp;
		logic rc;
	} xResult_t;

	// record handed to the next stage, address travels beside it
	typedef struct packed
	{
		logic valid;
		format_e format;
		primaryOp_e opcode;
		extOp_e xOpcode;
		logic xOpcodeValid;
		regIdx_t reg1;
		logic reg1En;
		regIdx_t reg2;
		logic reg2En;
		regIdx_t reg3;
		logic reg3En;
		logic [0:immWidth-1] imm;
		logic immValid;
		logic reg2ValOrZero;
		logic bit1;
	} decodedInstr_t;

endpackage

/* hdl/decodeUnit.sv */
`timescale 1ns/10ps

module decodeUnit #(
	parameter int addressSize = 64
)
(
	input logic clock_i,
	input logic arstN_i,
	input logic enable_i,
	input logic [0:decodePkg::instrWidth-1] instruction_i,
	input logic [0:addressSize-1] instructionAddress_i,
	output decodePkg::decodedInstr_t decoded_o,
	output logic [0:addressSize-1] instructionAddress_o
);
	import decodePkg::*;

	dResult_t dResult;
	dsResult_t dsResult;
	xResult_t xResult;
	primaryOp_e opcodeBypass;
	logic [0:addressSize-1] addressBypass;
	logic enableQ;

	//////////////////////////////
	// stage one
	//////////////////////////////
	dFormatDecoder dDecoder0 (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.result_o(dResult)
	);

	dsFormatDecoder dsDecoder0 (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.result_o(dsResult)
	);

	xFormatDecoder xDecoder0 (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enable_i),
		.instruction_i(instruction_i),
		.result_o(xResult)
	);

	// opcode and address ride beside the decoders
	always_ff @(posedge clock_i)
	begin
		if (enable_i)
		begin
			opcodeBypass <= primaryOp_e'(instruction_i[0:5]);
			addressBypass <= instructionAddress_i;
		end
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			enableQ <= 1'b0;
		else
			enableQ <= enable_i;
	end

	//////////////////////////////
	// stage two
	//////////////////////////////
	decodeMerge #(.addressSize(addressSize)) merge0 (
		.clock_i(clock_i),
		.arstN_i(arstN_i),
		.enable_i(enableQ),
		.opcode_i(opcodeBypass),
		.address_i(addressBypass),
		.dResult_i(dResult),
		.dsResult_i(dsResult),
		.xResult_i(xResult),
		.decoded_o(decoded_o),
		.instructionAddress_o(instructionAddress_o)
	);

	// fixed two cycle latency, address kept with its word
	twoCycleLatency: assert property (@(posedge clock_i) disable iff (!arstN_i)
		enable_i |-> ##2 (decoded_o.valid
			&& (instructionAddress_o == $past(instructionAddress_i, 2))));

endmodule

/* hdl/dsFormatDecoder.sv */
`timescale 1ns/10ps

module dsFormatDecoder
(
	input logic clock_i,
	input logic arstN_i,
	input logic enable_i,
	input logic [0:decodePkg::instrWidth-1] instruction_i,
	output decodePkg::dsResult_t result_o
);
	import decodePkg::*;

	primaryOp_e opcode;
	logic [0:1] subOp;
	dsResult_t nextResult;
	dsResult_t payloadQ;
	logic hitQ;

	assign opcode = primaryOp_e'(instruction_i[0:5]);
	assign subOp = instruction_i[30:31];

	// only sub-opcode 0 of ld and std is known here
	always_comb
	begin
		nextResult.hit = ((opcode == opLd) || (opcode == opStd)) && (subOp == 2'b00);
		nextResult.reg1 = instruction_i[6:10];
		nextResult.reg2 = instruction_i[11:15];
		nextResult.imm = instruction_i[16:29];
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			hitQ <= 1'b0;
		else if (enable_i)
			hitQ <= nextResult.hit;
	end

	always_ff @(posedge clock_i)
	begin
		if (enable_i)
			payloadQ <= nextResult;
	end

	always_comb
	begin
		result_o = payloadQ;
		result_o.hit = hitQ;
	end

endmodule

/* hdl/xFormatDecoder.sv */
`timescale 1ns/10ps

module xFormatDecoder
(
	input logic clock_i,
	input logic arstN_i,
	input logic enable_i,
	input logic [0:decodePkg::instrWidth-1] instruction_i,
	output decodePkg::xResult_t result_o
);
	import decodePkg::*;

	primaryOp_e opcode;
	extOp_e extOp;
	xResult_t nextResult;
	xResult_t payloadQ;
	logic hitQ;

	assign opcode = primaryOp_e'(instruction_i[0:5]);
	assign extOp = extOp_e'(instruction_i[21:30]);

	always_comb
	begin
		nextResult = '0;
		nextResult.reg1 = instruction_i[6:10];
		nextResult.reg2 = instruction_i[11:15];
		nextResult.reg3 = instruction_i[16:20];
		nextResult.extOp = extOp;
		nextResult.rc = instruction_i[31];
		if (opcode == opExt31)
		begin
			case (extOp)
				xoAdd:
					nextResult.hit = 1'b1;
				xoAnd, xoOr, xoXor:
				begin
					// destination is RA for logic ops
					nextResult.hit = 1'b1;
					nextResult.reg1 = instruction_i[11:15];
					nextResult.reg2 = instruction_i[6:10];
				end
				xoCmp:
				begin
					// BF sits in bits 6 to 8
					nextResult.hit = 1'b1;
					nextResult.reg1 = {2'b00, instruction_i[6:8]};
				end
				default:
					nextResult.hit = 1'b0;
			endcase
		end
	end

	always_ff @(posedge clock_i or negedge arstN_i)
	begin
		if (!arstN_i)
			hitQ <= 1'b0;
		else if (enable_i)
			hitQ <= nextResult.hit;
	end

	always_ff @(posedge clock_i)
	begin
		if (enable_i)
			payloadQ <= nextResult;
	end

	always_comb
	begin
		result_o = payloadQ;
		result_o.hit = hitQ;
	end

	// a claimed word must carry a known extended opcode downstream
	knownExtOp: assert property (@(posedge clock_i) disable iff (!arstN_i)
		result_o.hit |-> (result_o.extOp inside {xoCmp, xoAnd, xoXor, xoOr, xoAdd}));

endmodule

/* list.f */
hdl/decodePkg.sv
hdl/dFormatDecoder.sv
hdl/dsFormatDecoder.sv
hdl/xFormatDecoder.sv
hdl/decodeMerge.sv
hdl/decodeUnit.sv
bench/decodeUnitTb.sv
